// ==== bench/exec_tb.sv ====
/*
 * Testbench for the execute stage: drives the D port, collects W results
 * out of order by sequence number and checks them against a reference model.
 */

`timescale 1ns/1ps

`include "exec_defines.svh"

module exec_tb import exec_pkg::*; ();

  localparam int seq_depth = 2 ** `EXEC_SEQ_NUM_BITS;
  // ALU edges, multiply edges, latency pair, random and back-pressure streams
  localparam int n_ops = 10 * 7 + 3 * 7 + 2 + 200 + 200;

  logic clk;
  logic rst;
  logic d_val;
  logic d_rdy;
  logic [31:0] d_pc;
  logic [`EXEC_SEQ_NUM_BITS-1:0] d_seq_num;
  logic [31:0] d_op1;
  logic [31:0] d_op2;
  logic [4:0] d_waddr;
  rv_uop d_uop;
  logic w_val;
  logic w_rdy;
  logic [31:0] w_pc;
  logic [`EXEC_SEQ_NUM_BITS-1:0] w_seq_num;
  logic [4:0] w_waddr;
  logic [31:0] w_wdata;
  logic w_wen;

  // Expected results indexed by sequence number
  logic [31:0] exp_wdata [seq_depth];
  logic [31:0] exp_pc [seq_depth];
  logic [4:0] exp_waddr [seq_depth];
  logic exp_is_mul [seq_depth];
  logic pending [seq_depth];
  int accept_cyc [seq_depth];
  // Issue order per unit
  logic [`EXEC_SEQ_NUM_BITS-1:0] alu_q [$];
  logic [`EXEC_SEQ_NUM_BITS-1:0] mul_q [$];

  logic [`EXEC_SEQ_NUM_BITS-1:0] next_seq;
  logic [31:0] next_pc;
  logic [31:0] rng;
  logic [31:0] bp_rng;
  logic bp_en;
  logic lat_check;
  int cycle;
  int in_flight;
  // Payload captured while W is stalled
  logic held;
  logic [31:0] held_pc;
  logic [`EXEC_SEQ_NUM_BITS-1:0] held_seq;
  logic [4:0] held_waddr;
  logic [31:0] held_wdata;

  // Edge operands with shift amounts 0 and 31 among them
  logic [31:0] edge_a [7] = '{32'h0, 32'hffffffff, 32'h80000000, 32'h7fffffff,
                              32'h80000000, 32'hffffffff, 32'h80000000};
  logic [31:0] edge_b [7] = '{32'h0, 32'hffffffff, 32'h1f, 32'h80000000,
                              32'h0, 32'h7fffffff, 32'h80000000};

  exec_top UUT (
    .clk(clk), .rst(rst),
    .d_val(d_val), .d_rdy(d_rdy), .d_pc(d_pc), .d_seq_num(d_seq_num),
    .d_op1(d_op1), .d_op2(d_op2), .d_waddr(d_waddr), .d_uop(d_uop),
    .w_val(w_val), .w_rdy(w_rdy), .w_pc(w_pc), .w_seq_num(w_seq_num),
    .w_waddr(w_waddr), .w_wdata(w_wdata), .w_wen(w_wen)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Reference model and helpers
  // --------------------------------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Expected wdata straight from the RISC-V definitions
  function automatic logic [31:0] ref_result(input rv_uop uop, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [63:0] sprod;
    logic [63:0] uprod;
    logic [63:0] sra_wide;
    sra_wide = {{32{a[31]}}, a} >> b[4:0];
    // Low 64 bits of sign-extended operands give the signed product
    sprod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    uprod = {32'd0, a} * {32'd0, b};
    case (uop)
      uop_add:   return a + b;
      uop_sub:   return a - b;
      uop_and:   return a & b;
      uop_or:    return a | b;
      uop_xor:   return a ^ b;
      uop_sll:   return a << b[4:0];
      uop_srl:   return a >> b[4:0];
      uop_sra:   return sra_wide[31:0];
      // Flipping the sign bits turns signed order into unsigned order
      uop_slt:   return {31'd0, (a ^ 32'h80000000) < (b ^ 32'h80000000)};
      uop_sltu:  return {31'd0, a < b};
      uop_mul:   return uprod[31:0];
      uop_mulh:  return sprod[63:32];
      uop_mulhu: return uprod[63:32];
      default:   return 32'd0;
    endcase
  endfunction

  task automatic fail_stop();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_seq(input string name, input logic [`EXEC_SEQ_NUM_BITS-1:0] exp,
                           input logic [`EXEC_SEQ_NUM_BITS-1:0] act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  // --------------------------------------------------------------------------
  // Driver
  // --------------------------------------------------------------------------

  // Called just after a rising edge and returns on the accepting edge
  task automatic send_op(input rv_uop uop, input logic [31:0] a, input logic [31:0] b,
                         input logic [4:0] waddr);
    logic [`EXEC_SEQ_NUM_BITS-1:0] s;
    s = next_seq;
    // Sequence number still out so issue pauses until it retires
    if (pending[s] === 1'b1) begin
      d_val <= 1'b0;
      while (pending[s] === 1'b1) @(posedge clk);
    end
    exp_wdata[s] = ref_result(uop, a, b);
    exp_pc[s] = next_pc;
    exp_waddr[s] = waddr;
    exp_is_mul[s] = (uop == uop_mul) || (uop == uop_mulh) || (uop == uop_mulhu);
    pending[s] = 1'b1;
    in_flight++;
    if (exp_is_mul[s]) mul_q.push_back(s);
    else alu_q.push_back(s);
    d_val <= 1'b1;
    d_pc <= next_pc;
    d_seq_num <= s;
    d_op1 <= a;
    d_op2 <= b;
    d_waddr <= waddr;
    d_uop <= uop;
    do @(posedge clk); while (d_rdy !== 1'b1);
    accept_cyc[s] = cycle;
    next_seq = s + 1'b1;
    next_pc = next_pc + 32'd4;
  endtask

  task automatic finish_stream();
    d_val <= 1'b0;
    while (in_flight != 0) @(posedge clk);
  endtask

  // --------------------------------------------------------------------------
  // Monitor
  // --------------------------------------------------------------------------

  task automatic retire_result();
    logic [`EXEC_SEQ_NUM_BITS-1:0] s;
    s = w_seq_num;
    if (pending[s] !== 1'b1) begin
      $display("Result returned with a sequence number that is not outstanding: %h", s);
      fail_stop();
    end
    // In order within each unit
    if (exp_is_mul[s]) begin
      check_seq("w_seq_num", mul_q[0], s);
      void'(mul_q.pop_front());
    end else begin
      check_seq("w_seq_num", alu_q[0], s);
      void'(alu_q.pop_front());
    end
    check_data("w_wdata", exp_wdata[s], w_wdata);
    check_data("w_pc", exp_pc[s], w_pc);
    check_data("w_waddr", {27'd0, exp_waddr[s]}, {27'd0, w_waddr});
    check_bit("w_wen", exp_waddr[s] != 5'd0, w_wen);
    if (lat_check) begin
      check_data("latency", exp_is_mul[s] ? `EXEC_MUL_STAGES : 1, cycle - accept_cyc[s]);
    end
    pending[s] = 1'b0;
    in_flight--;
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    // Random W back-pressure when enabled
    bp_rng = xorshift(bp_rng);
    w_rdy <= bp_en ? bp_rng[3] : 1'b1;
  end

  always @(posedge clk) begin
    if (!rst) begin
      // Stalled payload must not move
      if (held) begin
        check_bit("w_val", 1'b1, w_val);
        check_data("w_pc", held_pc, w_pc);
        check_seq("w_seq_num", held_seq, w_seq_num);
        check_data("w_waddr", {27'd0, held_waddr}, {27'd0, w_waddr});
        check_data("w_wdata", held_wdata, w_wdata);
      end
      held = (w_val === 1'b1) && (w_rdy === 1'b0);
      held_pc = w_pc;
      held_seq = w_seq_num;
      held_waddr = w_waddr;
      held_wdata = w_wdata;
      if (w_val === 1'b1 && w_rdy === 1'b1) retire_result();
    end
  end

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  task automatic alu_edge_ops();
    int k;
    k = 0;
    // waddr cycles through 0 so w_wen low is covered
    for (int i = 0; i < 10; i++) begin
      for (int j = 0; j < 7; j++) begin
        send_op(rv_uop'(4'(i)), edge_a[j], edge_b[j], 5'(k));
        k++;
      end
    end
    finish_stream();
  endtask

  task automatic mul_edge_ops();
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 7; j++) begin
        send_op(rv_uop'(4'(10 + i)), edge_a[j], edge_b[j], 5'(j + 1));
      end
    end
    finish_stream();
  endtask

  task automatic latency_probe();
    lat_check <= 1'b1;
    send_op(uop_mulh, 32'h12345678, 32'h9abcdef0, 5'd3);
    finish_stream();
    send_op(uop_add, 32'h00000011, 32'h00000022, 5'd4);
    finish_stream();
    lat_check <= 1'b0;
  endtask

  // Back to back random operations over all thirteen micro-ops
  task automatic random_stream(input int n);
    rv_uop u;
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < n; i++) begin
      rng = xorshift(rng);
      u = rv_uop'(4'(rng % 13));
      rng = xorshift(rng);
      a = rng;
      rng = xorshift(rng);
      b = rng;
      send_op(u, a, b, rng[4:0] ^ rng[12:8]);
    end
    finish_stream();
  endtask

  initial begin
    rst = 1'b1;
    d_val = 1'b0;
    d_pc = 32'd0;
    d_seq_num = '0;
    d_op1 = 32'd0;
    d_op2 = 32'd0;
    d_waddr = 5'd0;
    d_uop = uop_add;
    w_rdy = 1'b1;
    bp_en = 1'b0;
    lat_check = 1'b0;
    cycle = 0;
    in_flight = 0;
    held = 1'b0;
    next_seq = '0;
    next_pc = 32'h00001000;
    rng = 32'h2eed673d;
    bp_rng = xorshift(32'h2eed673d);
    for (int i = 0; i < seq_depth; i++) pending[i] = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    // Idle state straight out of reset
    check_bit("w_val", 1'b0, w_val);
    check_bit("d_rdy", 1'b1, d_rdy);
    alu_edge_ops();
    mul_edge_ops();
    latency_probe();
    random_stream(200);
    bp_en <= 1'b1;
    random_stream(200);
    bp_en <= 1'b0;
    repeat (2) @(posedge clk);
    $display("Test passed");
    $finish;
  end

  // Watchdog sized from the operation count
  initial begin
    repeat (n_ops * 40 + 1000) @(posedge clk);
    $display("Timeout: the tests did not complete within the cycle budget");
    fail_stop();
  end

endmodule

// ==== compile.f ====
+incdir+design
design/exec_pkg.sv
design/exec_intf.sv
design/issue_router.sv
design/alu_unit.sv
design/pipelined_multiplier.sv
design/wb_arbiter.sv
design/exec_top.sv
bench/exec_tb.sv

// ==== design/alu_unit.sv ====
/*
 * Single-cycle integer ALU with a one-entry output register.
 * Result is valid the cycle after acceptance and held under back-pressure.
 */

`timescale 1ns/1ps

`include "exec_defines.svh"

module alu_unit import exec_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  exec_issue_if.dst req,
  exec_result_if.src rsp
);

  // Shift amount from low bits of op2
  logic [4:0]  shamt;
  logic [31:0] result;
  logic        accept;

  // Output register
  logic                          out_val;
  logic [31:0]                   out_pc;
  logic [`EXEC_SEQ_NUM_BITS-1:0] out_seq_num;
  logic [4:0]                    out_waddr;
  logic [31:0]                   out_wdata;

  // -------------------------------------------------------------------------
  // Datapath
  // -------------------------------------------------------------------------

  assign shamt = req.op2[4:0];

  always_comb begin
    case (req.uop)
      uop_add:  result = req.op1 + req.op2;
      uop_sub:  result = req.op1 - req.op2;
      uop_and:  result = req.op1 & req.op2;
      uop_or:   result = req.op1 | req.op2;
      uop_xor:  result = req.op1 ^ req.op2;
      uop_sll:  result = req.op1 << shamt;
      uop_srl:  result = req.op1 >> shamt;
      // Arithmetic shift keeps the sign bit
      uop_sra:  result = $unsigned($signed(req.op1) >>> shamt);
      uop_slt:  result = {31'd0, $signed(req.op1) < $signed(req.op2)};
      uop_sltu: result = {31'd0, req.op1 < req.op2};
      // Multiply ops never routed here
      default:  result = 32'd0;
    endcase
  end

  // -------------------------------------------------------------------------
  // Output register and handshake
  // -------------------------------------------------------------------------

  // Free when empty or draining this cycle
  assign req.rdy = ~out_val | rsp.rdy;
  assign accept  = req.val & req.rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_val <= 1'b0;
    end else if (req.rdy) begin
      out_val <= req.val;
    end
  end

  // Payload loads only on a real transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      out_pc      <= req.pc;
      out_seq_num <= req.seq_num;
      out_waddr   <= req.waddr;
      out_wdata   <= result;
    end
  end

  assign rsp.val     = out_val;
  assign rsp.pc      = out_pc;
  assign rsp.seq_num = out_seq_num;
  assign rsp.waddr   = out_waddr;
  assign rsp.wdata   = out_wdata;

endmodule

// ==== design/exec_defines.svh ====
/*
 * Build-time parameters of the integer execute stage.
 * Include wherever sequence-number width or multiplier depth is needed.
 */

`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Width of the instruction sequence number carried with every operation
`define EXEC_SEQ_NUM_BITS 5

// Default multiplier pipeline depth, legal range 1 to 8
// End-to-end multiply latency equals this value
`define EXEC_MUL_STAGES 4

`endif

// ==== design/exec_intf.sv ====
/*
 * Valid/ready links inside the execute stage.
 * exec_issue_if carries operations to a unit, exec_result_if its result.
 */

`timescale 1ns/1ps

`include "exec_defines.svh"

// Decoded operation toward a unit
interface exec_issue_if import exec_pkg::*; ();
  logic                          val;
  logic                          rdy;
  logic [31:0]                   pc;
  logic [`EXEC_SEQ_NUM_BITS-1:0] seq_num;
  logic [31:0]                   op1;
  logic [31:0]                   op2;
  logic [4:0]                    waddr;
  rv_uop                         uop;

  modport src (output val, pc, seq_num, op1, op2, waddr, uop, input rdy);
  modport dst (input val, pc, seq_num, op1, op2, waddr, uop, output rdy);
endinterface

// Register write coming back from a unit
interface exec_result_if ();
  logic                          val;
  logic                          rdy;
  logic [31:0]                   pc;
  logic [`EXEC_SEQ_NUM_BITS-1:0] seq_num;
  logic [4:0]                    waddr;
  logic [31:0]                   wdata;

  modport src (output val, pc, seq_num, waddr, wdata, input rdy);
  modport dst (input val, pc, seq_num, waddr, wdata, output rdy);
endinterface

// ==== design/exec_pkg.sv ====
/*
 * Types shared across the execute stage: micro-op encoding,
 * the 64-bit product union and the unit-class helper.
 */

package exec_pkg;

  // Supported micro-ops, 4-bit encoding as produced by decode
  typedef enum logic [3:0] {
    uop_add   = 4'd0,
    uop_sub   = 4'd1,
    uop_and   = 4'd2,
    uop_or    = 4'd3,
    uop_xor   = 4'd4,
    uop_sll   = 4'd5,
    uop_srl   = 4'd6,
    uop_sra   = 4'd7,
    uop_slt   = 4'd8,
    uop_sltu  = 4'd9,
    uop_mul   = 4'd10,
    uop_mulh  = 4'd11,
    uop_mulhu = 4'd12
  } rv_uop;

  // Product halves, hi first so it maps onto bits 63:32
  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } mul_halves_s;

  // Full product or its two halves
  typedef union packed {
    logic [63:0] word;
    mul_halves_s half;
  } mul_product_u;

  // Multiply class, steered to the multiplier
  function automatic logic is_mul_uop(rv_uop uop);
    return uop inside {uop_mul, uop_mulh, uop_mulhu};
  endfunction

endpackage

// ==== design/exec_top.sv ====
/*
 * Integer execute stage top level: D port in, W port out, plain ports.
 * Router feeds ALU and multiplier, arbiter merges their results.
 */

`timescale 1ns/1ps

`include "exec_defines.svh"

module exec_top import exec_pkg::*; (
  input  logic                          clk,
  input  logic                          rst,

  // Decode side
  input  logic                          d_val,
  output logic                          d_rdy,
  input  logic [31:0]                   d_pc,
  input  logic [`EXEC_SEQ_NUM_BITS-1:0] d_seq_num,
  input  logic [31:0]                   d_op1,
  input  logic [31:0]                   d_op2,
  input  logic [4:0]                    d_waddr,
  input  rv_uop                         d_uop,

  // Writeback side
  output logic                          w_val,
  input  logic                          w_rdy,
  output logic [31:0]                   w_pc,
  output logic [`EXEC_SEQ_NUM_BITS-1:0] w_seq_num,
  output logic [4:0]                    w_waddr,
  output logic [31:0]                   w_wdata,
  output logic                          w_wen
);

  exec_issue_if  d_if ();
  exec_issue_if  alu_req ();
  exec_issue_if  mul_req ();
  exec_result_if alu_rsp ();
  exec_result_if mul_rsp ();

  // D ports onto the router's input link
  assign d_if.val     = d_val;
  assign d_if.pc      = d_pc;
  assign d_if.seq_num = d_seq_num;
  assign d_if.op1     = d_op1;
  assign d_if.op2     = d_op2;
  assign d_if.waddr   = d_waddr;
  assign d_if.uop     = d_uop;
  assign d_rdy        = d_if.rdy;

  // -------------------------------------------------------------------------
  // Units
  // -------------------------------------------------------------------------

  issue_router u_router (.d(d_if), .alu(alu_req), .mul(mul_req));

  alu_unit u_alu (.clk(clk), .rst(rst), .req(alu_req), .rsp(alu_rsp));

  pipelined_multiplier #(.p_stages(`EXEC_MUL_STAGES)) u_mul (
    .clk(clk), .rst(rst), .req(mul_req), .rsp(mul_rsp)
  );

  wb_arbiter u_arb (
    .clk(clk), .rst(rst), .alu(alu_rsp), .mul(mul_rsp),
    .w_val(w_val), .w_rdy(w_rdy), .w_pc(w_pc), .w_seq_num(w_seq_num),
    .w_waddr(w_waddr), .w_wdata(w_wdata), .w_wen(w_wen)
  );

endmodule

// ==== design/issue_router.sv ====
/*
 * Issue router: steers each decoded operation to the ALU or the
 * multiplier and returns the chosen unit's ready. Purely combinational.
 */

`timescale 1ns/1ps

module issue_router import exec_pkg::*; (
  exec_issue_if.dst d,
  exec_issue_if.src alu,
  exec_issue_if.src mul
);

  // Operation class, decided only here
  logic to_mul;

  assign to_mul = is_mul_uop(d.uop);

  // -------------------------------------------------------------------------
  // Valid steering
  // -------------------------------------------------------------------------

  // Only the selected unit sees val
  assign alu.val = d.val & ~to_mul;
  assign mul.val = d.val & to_mul;

  // -------------------------------------------------------------------------
  // Payload broadcast
  // -------------------------------------------------------------------------

  // Same payload to both units, val picks the taker
  assign alu.pc      = d.pc;
  assign alu.seq_num = d.seq_num;
  assign alu.op1     = d.op1;
  assign alu.op2     = d.op2;
  assign alu.waddr   = d.waddr;
  assign alu.uop     = d.uop;

  assign mul.pc      = d.pc;
  assign mul.seq_num = d.seq_num;
  assign mul.op1     = d.op1;
  assign mul.op2     = d.op2;
  assign mul.waddr   = d.waddr;
  assign mul.uop     = d.uop;

  // Ready back from whichever unit owns this micro-op
  assign d.rdy = to_mul ? mul.rdy : alu.rdy;

endmodule

// ==== design/pipelined_multiplier.sv ====
/*
 * Pipelined 32x32 multiplier for MUL, MULH and MULHU.
 * p_stages registers deep; the whole pipe freezes when the last stage stalls.
 */

`timescale 1ns/1ps

`include "exec_defines.svh"

module pipelined_multiplier import exec_pkg::*; #(
  parameter int p_stages = `EXEC_MUL_STAGES
) (
  input  logic       clk,
  input  logic       rst,
  exec_issue_if.dst  req,
  exec_result_if.src rsp
);

  localparam int last = p_stages - 1;

  // -------------------------------------------------------------------------
  // Operand extension and product
  // -------------------------------------------------------------------------

  // Signed view for MUL and MULH, unsigned only for MULHU
  logic               signed_ops;
  logic               sel_hi;
  logic signed [32:0] op1_ext;
  logic signed [32:0] op2_ext;
  logic signed [65:0] full_prod;
  mul_product_u       prod;

  assign signed_ops = (req.uop != uop_mulhu);
  // MUL wants the low word, the others the high word
  assign sel_hi     = (req.uop != uop_mul);

  assign op1_ext = {signed_ops & req.op1[31], req.op1};
  assign op2_ext = {signed_ops & req.op2[31], req.op2};

  // 33x33 signed covers both signed and unsigned 32-bit cases
  assign full_prod = op1_ext * op2_ext;
  assign prod.word = full_prod[63:0];

  // -------------------------------------------------------------------------
  // Pipeline registers
  // -------------------------------------------------------------------------

  logic                          stg_val     [p_stages];
  mul_product_u                  stg_prod    [p_stages];
  logic                          stg_sel_hi  [p_stages];
  logic [31:0]                   stg_pc      [p_stages];
  logic [`EXEC_SEQ_NUM_BITS-1:0] stg_seq_num [p_stages];
  logic [4:0]                    stg_waddr   [p_stages];

  // All stages move together unless the tail is stuck
  logic advance;

  assign advance = ~stg_val[last] | rsp.rdy;
  assign req.rdy = advance;

  // Valid bits, cleared by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < p_stages; i++) begin
        stg_val[i] <= 1'b0;
      end
    end else if (advance) begin
      stg_val[0] <= req.val;
      for (int i = 1; i < p_stages; i++) begin
        stg_val[i] <= stg_val[i-1];
      end
    end
  end

  // Payload shifts alongside, bubbles carry don't-care data
  always_ff @(posedge clk) begin
    if (advance) begin
      stg_prod[0]    <= prod;
      stg_sel_hi[0]  <= sel_hi;
      stg_pc[0]      <= req.pc;
      stg_seq_num[0] <= req.seq_num;
      stg_waddr[0]   <= req.waddr;
      for (int i = 1; i < p_stages; i++) begin
        stg_prod[i]    <= stg_prod[i-1];
        stg_sel_hi[i]  <= stg_sel_hi[i-1];
        stg_pc[i]      <= stg_pc[i-1];
        stg_seq_num[i] <= stg_seq_num[i-1];
        stg_waddr[i]   <= stg_waddr[i-1];
      end
    end
  end

  // -------------------------------------------------------------------------
  // Result select
  // -------------------------------------------------------------------------

  // Half picked from the union view
  assign rsp.wdata   = stg_sel_hi[last] ? stg_prod[last].half.hi
                                        : stg_prod[last].half.lo;
  assign rsp.val     = stg_val[last];
  assign rsp.pc      = stg_pc[last];
  assign rsp.seq_num = stg_seq_num[last];
  assign rsp.waddr   = stg_waddr[last];

endmodule

// ==== design/wb_arbiter.sv ====
/*
 * Writeback arbiter: round-robin merge of ALU and multiplier results
 * onto the single W port. Grant holds while W is stalled.
 */

`timescale 1ns/1ps

`include "exec_defines.svh"

module wb_arbiter (
  input  logic                          clk,
  input  logic                          rst,
  exec_result_if.dst                    alu,
  exec_result_if.dst                    mul,
  output logic                          w_val,
  input  logic                          w_rdy,
  output logic [31:0]                   w_pc,
  output logic [`EXEC_SEQ_NUM_BITS-1:0] w_seq_num,
  output logic [4:0]                    w_waddr,
  output logic [31:0]                   w_wdata,
  output logic                          w_wen
);

  // Set when the multiplier has priority
  logic prio_mul;
  logic grant_mul;

  // Mul wins when alone or when it holds priority
  assign grant_mul = mul.val & (~alu.val | prio_mul);

  // Stall keeps the current winner so W stays stable,
  // a transfer hands priority to the other unit
  always_ff @(posedge clk) begin
    if (rst) begin
      prio_mul <= 1'b0;
    end else if (w_val) begin
      prio_mul <= w_rdy ? ~grant_mul : grant_mul;
    end
  end

  // -------------------------------------------------------------------------
  // W mux
  // -------------------------------------------------------------------------

  assign w_val     = alu.val | mul.val;
  assign w_pc      = grant_mul ? mul.pc      : alu.pc;
  assign w_seq_num = grant_mul ? mul.seq_num : alu.seq_num;
  assign w_waddr   = grant_mul ? mul.waddr   : alu.waddr;
  assign w_wdata   = grant_mul ? mul.wdata   : alu.wdata;

  // x0 is never written
  assign w_wen = (w_waddr != 5'd0);

  // Ready only to the winner
  assign alu.rdy = w_rdy & ~grant_mul;
  assign mul.rdy = w_rdy & grant_mul;

endmodule
